// File: pipe_trace_top.f
hw/trace_pkg.sv
hw/tag_tracker.sv
hw/trace_record_store.sv
hw/retire_fifo.sv
hw/trace_axil_regs.sv
hw/pipe_trace_top.sv
test/trace_checker.sv
test/tb_pipe_trace.sv

// File: run_sim.sh
#!/bin/sh
# build the trace unit testbench with verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module tb_pipe_trace \
    -f pipe_trace_top.f -o tb_pipe_trace \
    && ./obj_dir/tb_pipe_trace > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Verification passed" sim.log \
    && exit 0 \
    || exit 1

// File: test/tb_pipe_trace.sv
/*
 * pipeline trace testbench
 * pseudo-cpu with random stall drives the trace port, an axi4-lite
 * master drains the retire queue, trace_checker compares the reads
 */
`timescale 1ns/10ps

module tb_pipe_trace;

    localparam int TIMEOUT = 200;

    logic clk;
    logic rst;
    logic stall;
    trace_pkg::word_t if_pc, if_instr, ex_result, mem_addr, wb_data;
    trace_pkg::axil_addr_t awaddr, araddr;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    trace_pkg::word_t wdata, rdata;
    logic [3:0] wstrb;
    trace_pkg::axil_resp_t bresp, rresp;

    // expected records toward the checker
    logic exp_push;
    trace_pkg::rec_t exp_rec;
    int err_count;
    int check_count;

    integer seed = 32'ha2b3;
    // fetches still allowed, stall is held high once this hits zero
    int issue_left;
    logic random_stall;
    logic c_stall;

    // cpu-side five-stage tag model
    logic m_vif, m_vid, m_vex, m_vmem, m_vwb, m_fetch;
    trace_pkg::tag_t m_tif, m_tid, m_tex, m_tmem, m_twb, m_next;
    // expected fields per tag
    trace_pkg::word_t e_pc [256];
    trace_pkg::word_t e_instr [256];
    trace_pkg::word_t e_res [256];
    trace_pkg::word_t e_addr [256];
    trace_pkg::stall_cnt_t e_cnt [256];

    pipe_trace_top pipe_trace_top_inst (.*);

    trace_checker trace_checker_inst (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // pseudo-cpu
    ////////////////////////////////////////////////////////////////////////////

    // same hold-and-bubble rule the cpu follows
    task automatic step_model();
        if (rst) begin
            {m_vif, m_vid, m_vex, m_vmem, m_vwb} = '0;
            m_fetch = 1'b0;
            m_next  = '0;
        end else begin
            m_vwb   = m_vmem;
            m_twb   = m_tmem;
            m_vmem  = m_vex;
            m_tmem  = m_tex;
            m_vex   = m_vid && !stall;
            m_tex   = m_tid;
            m_fetch = !stall;
            if (!stall) begin
                m_vid  = m_vif;
                m_tid  = m_tif;
                m_vif  = 1'b1;
                m_tif  = m_next;
                m_next = m_next + 1'b1;
                if (issue_left > 0)
                    issue_left = issue_left - 1;
            end
        end
    endtask

    task automatic drive_cpu();
        trace_pkg::rec_t r;
        stall     = c_stall;
        if_pc     = $random(seed);
        if_instr  = $random(seed);
        ex_result = $random(seed);
        mem_addr  = $random(seed);
        wb_data   = $random(seed);
        if (m_fetch) begin
            e_pc[m_tif]    = if_pc;
            e_instr[m_tif] = if_instr;
            e_cnt[m_tif]   = '0;
        end
        // stall cycles count for whatever sits in fetch or decode
        if (c_stall && m_vif && e_cnt[m_tif] != 8'hff)
            e_cnt[m_tif] = e_cnt[m_tif] + 1'b1;
        if (c_stall && m_vid && e_cnt[m_tid] != 8'hff)
            e_cnt[m_tid] = e_cnt[m_tid] + 1'b1;
        if (m_vex)
            e_res[m_tex] = ex_result;
        if (m_vmem)
            e_addr[m_tmem] = mem_addr;
        exp_push = m_vwb;
        if (m_vwb) begin
            r[0]    = {16'h0, e_cnt[m_twb], m_twb};
            r[1]    = e_pc[m_twb];
            r[2]    = e_instr[m_twb];
            r[3]    = e_res[m_twb];
            r[4]    = e_addr[m_twb];
            r[5]    = wb_data;
            exp_rec = r;
        end
    endtask

    // model and stall choice at the edge, inputs change 10 ns later
    initial begin
        forever begin
            @(posedge clk);
            step_model();
            c_stall = (issue_left == 0) || (random_stall && ($random(seed) % 4 == 0));
            #10;
            drive_cpu();
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // axi4-lite master
    ////////////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $finish;
    endtask

    task automatic axi_read(input trace_pkg::axil_addr_t addr, output trace_pkg::word_t data);
        int n;
        logic took;
        araddr  = addr;
        arvalid = 1'b1;
        n       = 0;
        took    = 1'b0;
        while (!took) begin
            took = arready;
            @(posedge clk);
            #10;
            n++;
            if (n > TIMEOUT)
                abort_run("timeout waiting for arready");
        end
        arvalid = 1'b0;
        rready  = 1'b1;
        n       = 0;
        while (!rvalid) begin
            @(posedge clk);
            #10;
            n++;
            if (n > TIMEOUT)
                abort_run("timeout waiting for rvalid");
        end
        data = rdata;
        @(posedge clk);
        #10;
        rready = 1'b0;
    endtask

    // gap delays the data phase after the address phase
    task automatic axi_write(input trace_pkg::axil_addr_t addr, input trace_pkg::word_t data,
                             input int gap);
        int n;
        awaddr  = addr;
        awvalid = 1'b1;
        repeat (gap) begin
            @(posedge clk);
            #10;
        end
        wdata  = data;
        wstrb  = 4'hf;
        wvalid = 1'b1;
        n      = 0;
        while (!(awready && wready)) begin
            @(posedge clk);
            #10;
            n++;
            if (n > TIMEOUT)
                abort_run("timeout waiting for awready and wready");
        end
        @(posedge clk);
        #10;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        bready  = 1'b1;
        n       = 0;
        while (!bvalid) begin
            @(posedge clk);
            #10;
            n++;
            if (n > TIMEOUT)
                abort_run("timeout waiting for bvalid");
        end
        @(posedge clk);
        #10;
        bready = 1'b0;
    endtask

    // read status, then every held record and pop it
    task automatic drain_queue();
        trace_pkg::word_t st;
        trace_pkg::word_t w;
        int held;
        int i;
        int k;
        axi_read(8'h00, st);
        held = int'(st[4:0]);
        for (i = 0; i < held; i++) begin
            for (k = 0; k < trace_pkg::REC_WORDS; k++)
                axi_read(8'(4 + 4 * k), w);
            axi_write(8'h1C, '0, 0);
        end
    endtask

    // issue n fetches, then wait until execute to write-back stay empty
    task automatic issue(input int n, input logic with_stall);
        int cyc;
        int quiet;
        random_stall = with_stall;
        issue_left   = n;
        cyc          = 0;
        quiet        = 0;
        while (quiet < 3) begin
            @(posedge clk);
            #10;
            cyc++;
            if (issue_left == 0 && !m_vex && !m_vmem && !m_vwb)
                quiet++;
            else
                quiet = 0;
            if (cyc > TIMEOUT)
                abort_run("timeout waiting for the pipeline to drain");
        end
    endtask

    // rounds of 12 keep the queue below full
    task automatic run_rounds(input int total, input logic with_stall);
        int done;
        done = 0;
        while (done < total) begin
            issue(12, with_stall);
            drain_queue();
            done = done + 12;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        if (err_count == errs_before)
            $display("test %0d %s: ok", num, name);
        else
            $display("test %0d %s: %0d errors", num, name, err_count - errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int errs;
        int k;
        trace_pkg::word_t st;
        trace_pkg::word_t w;
        rst          = 1'b1;
        stall        = 1'b1;
        {if_pc, if_instr, ex_result, mem_addr, wb_data} = '0;
        {awaddr, araddr, wdata, wstrb} = '0;
        {awvalid, wvalid, bready, arvalid, rready} = '0;
        issue_left   = 0;
        random_stall = 1'b0;
        repeat (16) @(posedge clk);
        #10;
        rst = 1'b0;

        // two batches of 12 and 10 fetches retire tags 0 to 19
        // tags 20 and 21 stay held in fetch and decode
        errs = err_count;
        issue(12, 1'b0);
        drain_queue();
        issue(10, 1'b0);
        drain_queue();
        report_test(1, "in-order retire without stall", errs);

        errs = err_count;
        run_rounds(60, 1'b1);
        report_test(2, "stall counts under random stall", errs);

        errs = err_count;
        run_rounds(300, 1'b1);
        report_test(3, "tag wrap past 255", errs);

        // more than 16 retire with nobody draining
        errs = err_count;
        issue(22, 1'b0);
        axi_read(8'h00, st);
        axi_write(8'h00, 32'h0000_0100, 0);
        axi_read(8'h00, st);
        drain_queue();
        report_test(4, "overflow and clear", errs);

        errs = err_count;
        for (k = 0; k < trace_pkg::REC_WORDS; k++)
            axi_read(8'(4 + 4 * k), w);
        axi_write(8'h1C, '0, 0);
        axi_read(8'h00, st);
        report_test(5, "empty queue reads and pop", errs);

        // write data trails the address by three cycles
        errs = err_count;
        issue(3, 1'b0);
        axi_write(8'h1C, '0, 3);
        axi_read(8'h00, st);
        drain_queue();
        report_test(6, "split write handshake", errs);

        $display("checks %0d errors %0d", check_count, err_count);
        if (err_count == 0 && check_count > 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: test/trace_checker.sv
/*
 * trace checker
 * keeps the model retire queue, watches the axi4-lite bus and compares
 * every read with the model, counts checks and errors
 */
`timescale 1ns/10ps

module trace_checker (
    input  logic                  clk,
    input  logic                  rst,
    // expected records from the pseudo-cpu
    input  logic                  exp_push,
    input  trace_pkg::rec_t       exp_rec,
    // bus, watched only
    input  trace_pkg::axil_addr_t awaddr,
    input  logic                  awvalid,
    input  logic                  awready,
    input  trace_pkg::word_t      wdata,
    input  logic                  wvalid,
    input  logic                  wready,
    input  trace_pkg::axil_resp_t bresp,
    input  logic                  bvalid,
    input  logic                  bready,
    input  trace_pkg::axil_addr_t araddr,
    input  logic                  arvalid,
    input  logic                  arready,
    input  trace_pkg::word_t      rdata,
    input  trace_pkg::axil_resp_t rresp,
    input  logic                  rvalid,
    input  logic                  rready,
    output int                    err_count,
    output int                    check_count
);

    // records the dut queue should hold, head first
    trace_pkg::rec_t model_q[$];
    logic model_ovf;
    trace_pkg::axil_addr_t rd_addr;

    function automatic string field_name(input trace_pkg::axil_addr_t a);
        case (a)
            8'h00: return "status";
            8'h04: return "tag_stall";
            8'h08: return "pc";
            8'h0C: return "instr";
            8'h10: return "result";
            8'h14: return "addr";
            8'h18: return "wb_data";
            default: return "unmapped";
        endcase
    endfunction

    // what a read should return, given the model queue
    function automatic trace_pkg::word_t expected_word(input trace_pkg::axil_addr_t a);
        trace_pkg::word_t w;
        int idx;
        w   = '0;
        idx = (int'(a) - 4) / 4;
        if (a == 8'h00) begin
            w[4:0] = 5'(model_q.size());
            w[8]   = model_ovf;
        end else if (idx >= 0 && idx < trace_pkg::REC_WORDS && model_q.size() != 0) begin
            // record words of an empty queue stay zero
            w = model_q[0][idx];
        end
        return w;
    endfunction

    task automatic compare(input string name, input trace_pkg::word_t exp,
                           input trace_pkg::word_t act);
        check_count = check_count + 1;
        if (exp !== act) begin
            err_count = err_count + 1;
            $display("ERR %s expected %08h actual %08h", name, exp, act);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // bus watch
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (rst) begin
            model_q.delete();
            model_ovf   = 1'b0;
            rd_addr     = '0;
            err_count   = 0;
            check_count = 0;
        end else begin
            // full queue drops the record and flags overflow
            if (exp_push) begin
                if (model_q.size() < trace_pkg::FIFO_DEPTH)
                    model_q.push_back(exp_rec);
                else
                    model_ovf = 1'b1;
            end
            if (awvalid && awready && wvalid && wready) begin
                if (awaddr == 8'h1C && model_q.size() != 0)
                    void'(model_q.pop_front());
                if (awaddr == 8'h00 && wdata[8])
                    model_ovf = 1'b0;
            end
            if (arvalid && arready)
                rd_addr = araddr;
            if (rvalid && rready) begin
                compare(field_name(rd_addr), expected_word(rd_addr), rdata);
                compare("rresp", 32'h0, 32'(rresp));
            end
            if (bvalid && bready)
                compare("bresp", 32'h0, 32'(bresp));
        end
    end

endmodule

// File: hw/pipe_trace_top.sv
/*
 * pipeline trace unit
 * tags cpu instructions, collects per-stage values into records and
 * queues retired records for reading over axi4-lite
 */
`timescale 1ns/10ps

module pipe_trace_top (
    input  logic                  clk,
    input  logic                  rst,
    // cpu trace port
    input  logic                  stall,
    input  trace_pkg::word_t      if_pc,
    input  trace_pkg::word_t      if_instr,
    input  trace_pkg::word_t      ex_result,
    input  trace_pkg::word_t      mem_addr,
    input  trace_pkg::word_t      wb_data,
    // axi4-lite slave
    input  trace_pkg::axil_addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  trace_pkg::word_t      wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output trace_pkg::axil_resp_t bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  trace_pkg::axil_addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output trace_pkg::word_t      rdata,
    output trace_pkg::axil_resp_t rresp,
    output logic                  rvalid,
    input  logic                  rready
);

    logic fetch_new, leave_id, valid_id, valid_ex, valid_mem, valid_wb;
    trace_pkg::tag_t tag_if, tag_id, tag_ex, tag_mem, tag_wb;
    logic push, pop, clear_ovf, overflow;
    trace_pkg::rec_t rec_in, head;
    trace_pkg::fifo_cnt_t count;

    tag_tracker tag_tracker_inst (.*);

    trace_record_store trace_record_store_inst (.*);

    retire_fifo retire_fifo_inst (.*);

    trace_axil_regs trace_axil_regs_inst (.*);

endmodule

// File: hw/trace_axil_regs.sv
/*
 * trace register slave
 * axi4-lite slave with status, the head record words and a pop command,
 * one transaction outstanding per direction
 */
`timescale 1ns/10ps

module trace_axil_regs (
    input  logic                  clk,
    input  logic                  rst,
    input  trace_pkg::axil_addr_t awaddr,
    input  logic                  awvalid,
    output logic                  awready,
    input  trace_pkg::word_t      wdata,
    input  logic [3:0]            wstrb,
    input  logic                  wvalid,
    output logic                  wready,
    output trace_pkg::axil_resp_t bresp,
    output logic                  bvalid,
    input  logic                  bready,
    input  trace_pkg::axil_addr_t araddr,
    input  logic                  arvalid,
    output logic                  arready,
    output trace_pkg::word_t      rdata,
    output trace_pkg::axil_resp_t rresp,
    output logic                  rvalid,
    input  logic                  rready,
    input  trace_pkg::rec_t       head,
    input  trace_pkg::fifo_cnt_t  count,
    input  logic                  overflow,
    output logic                  pop,
    output logic                  clear_ovf
);

    trace_pkg::axil_rd_state_t rd_state;
    trace_pkg::axil_wr_state_t wr_state;

    // register map decode for reads
    function automatic trace_pkg::word_t reg_read(input trace_pkg::axil_addr_t a);
        trace_pkg::axil_addr_t rec_off;
        trace_pkg::word_t      val;
        rec_off = a - trace_pkg::REG_REC0;
        val     = '0;
        if (a == trace_pkg::REG_STATUS) begin
            val[$bits(count)-1:0]         = count;
            val[trace_pkg::STATUS_OVF_BIT] = overflow;
        end else if (a >= trace_pkg::REG_REC0 && a < trace_pkg::REG_POP && a[1:0] == 2'b00) begin
            // empty queue reads back zero
            if (count != '0)
                val = head[rec_off[7:2]];
        end
        return val;
    endfunction

    assign rresp = trace_pkg::RESP_OKAY;
    assign bresp = trace_pkg::RESP_OKAY;

    ////////////////////////////////////////////////////////////////////////////
    // read channel
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_state <= trace_pkg::RD_IDLE;
            arready  <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            case (rd_state)
                trace_pkg::RD_IDLE: begin
                    arready <= 1'b1;
                    if (arvalid && arready) begin
                        arready  <= 1'b0;
                        rvalid   <= 1'b1;
                        rd_state <= trace_pkg::RD_DATA;
                    end
                end
                trace_pkg::RD_DATA: begin
                    // hold data until the master takes it
                    if (rready) begin
                        rvalid   <= 1'b0;
                        arready  <= 1'b1;
                        rd_state <= trace_pkg::RD_IDLE;
                    end
                end
                default: rd_state <= trace_pkg::RD_IDLE;
            endcase
        end
    end

    // read data is payload, latched at the address handshake
    always_ff @(posedge clk) begin
        if (rd_state == trace_pkg::RD_IDLE && arvalid && arready)
            rdata <= reg_read(araddr);
    end

    ////////////////////////////////////////////////////////////////////////////
    // write channel
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_state  <= trace_pkg::WR_IDLE;
            awready   <= 1'b0;
            wready    <= 1'b0;
            bvalid    <= 1'b0;
            pop       <= 1'b0;
            clear_ovf <= 1'b0;
        end else begin
            pop       <= 1'b0;
            clear_ovf <= 1'b0;
            case (wr_state)
                trace_pkg::WR_IDLE: begin
                    // address and data may arrive in either order
                    if (awvalid && wvalid) begin
                        awready  <= 1'b1;
                        wready   <= 1'b1;
                        wr_state <= trace_pkg::WR_ACK;
                    end
                end
                trace_pkg::WR_ACK: begin
                    // handshake cycle, decode the command
                    awready  <= 1'b0;
                    wready   <= 1'b0;
                    bvalid   <= 1'b1;
                    wr_state <= trace_pkg::WR_RESP;
                    if (awaddr == trace_pkg::REG_POP)
                        pop <= 1'b1;
                    if (awaddr == trace_pkg::REG_STATUS && wstrb[1] &&
                        wdata[trace_pkg::STATUS_OVF_BIT])
                        clear_ovf <= 1'b1;
                end
                trace_pkg::WR_RESP: begin
                    if (bready) begin
                        bvalid   <= 1'b0;
                        wr_state <= trace_pkg::WR_IDLE;
                    end
                end
                default: wr_state <= trace_pkg::WR_IDLE;
            endcase
        end
    end

endmodule

// File: hw/retire_fifo.sv
/*
 * retire fifo
 * circular buffer of retired records with a show-ahead head and a
 * sticky overflow flag for pushes dropped while full
 */
`timescale 1ns/10ps

module retire_fifo (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 push,
    input  logic                 pop,
    input  logic                 clear_ovf,
    input  trace_pkg::rec_t      rec_in,
    output trace_pkg::rec_t      head,
    output trace_pkg::fifo_cnt_t count,
    output logic                 overflow
);

    trace_pkg::rec_t     mem [trace_pkg::FIFO_DEPTH];
    trace_pkg::fifo_ptr_t wr_ptr;
    trace_pkg::fifo_ptr_t rd_ptr;
    logic do_push;
    logic do_pop;

    // pop on empty is ignored
    assign do_pop  = pop && (count != '0);
    // a full queue still takes a push when a pop frees the head
    assign do_push = push && ((count != trace_pkg::FIFO_DEPTH) || do_pop);

    // show-ahead head
    assign head = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= rec_in;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
            // dropped push wins over a clear in the same cycle
            if (push && !do_push)
                overflow <= 1'b1;
            else if (clear_ovf)
                overflow <= 1'b0;
        end
    end

    a_count_bound: assert property (
        @(posedge clk) disable iff (rst) count <= trace_pkg::FIFO_DEPTH
    );

endmodule

// File: hw/trace_record_store.sv
/*
 * trace record store
 * tag-indexed slots filled stage by stage, the finished record is
 * registered and pushed one clock after write-back
 */
`timescale 1ns/10ps

module trace_record_store (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             fetch_new,
    input  logic             leave_id,
    input  logic             valid_id,
    input  logic             valid_ex,
    input  logic             valid_mem,
    input  logic             valid_wb,
    input  trace_pkg::tag_t  tag_if,
    input  trace_pkg::tag_t  tag_id,
    input  trace_pkg::tag_t  tag_ex,
    input  trace_pkg::tag_t  tag_mem,
    input  trace_pkg::tag_t  tag_wb,
    input  trace_pkg::word_t if_pc,
    input  trace_pkg::word_t if_instr,
    input  trace_pkg::word_t ex_result,
    input  trace_pkg::word_t mem_addr,
    input  trace_pkg::word_t wb_data,
    output logic             push,
    output trace_pkg::rec_t  rec_in
);

    // per-slot fields, write-back data goes straight into the record
    trace_pkg::word_t      pc_slot     [trace_pkg::TAG_SLOTS];
    trace_pkg::word_t      instr_slot  [trace_pkg::TAG_SLOTS];
    trace_pkg::word_t      result_slot [trace_pkg::TAG_SLOTS];
    trace_pkg::word_t      addr_slot   [trace_pkg::TAG_SLOTS];
    trace_pkg::stall_cnt_t cnt_slot    [trace_pkg::TAG_SLOTS];

    // fetch has held an instruction since the first fetch_new
    logic if_busy;
    logic slot_clash;
    trace_pkg::slot_t s_if, s_id, s_ex, s_mem, s_wb;

    function automatic trace_pkg::stall_cnt_t sat_inc(input trace_pkg::stall_cnt_t c);
        return (c == '1) ? c : c + 1'b1;
    endfunction

    // low tag bits pick the slot
    assign s_if  = tag_if[trace_pkg::SLOT_W-1:0];
    assign s_id  = tag_id[trace_pkg::SLOT_W-1:0];
    assign s_ex  = tag_ex[trace_pkg::SLOT_W-1:0];
    assign s_mem = tag_mem[trace_pkg::SLOT_W-1:0];
    assign s_wb  = tag_wb[trace_pkg::SLOT_W-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // slot writes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // fetch opens the slot, count restarts here
        if (fetch_new) begin
            pc_slot[s_if]    <= if_pc;
            instr_slot[s_if] <= if_instr;
            cnt_slot[s_if]   <= stall ? 8'd1 : 8'd0;
        end else if (if_busy && stall) begin
            cnt_slot[s_if] <= sat_inc(cnt_slot[s_if]);
        end
        // count keeps running in decode until it leaves
        if (valid_id && !leave_id)
            cnt_slot[s_id] <= sat_inc(cnt_slot[s_id]);
        if (valid_ex)
            result_slot[s_ex] <= ex_result;
        if (valid_mem)
            addr_slot[s_mem] <= mem_addr;
        // retire, complete record for the queue
        if (valid_wb)
            rec_in <= {wb_data, addr_slot[s_wb], result_slot[s_wb], instr_slot[s_wb],
                       pc_slot[s_wb], {16'h0, cnt_slot[s_wb], tag_wb}};
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            if_busy <= 1'b0;
            push    <= 1'b0;
        end else begin
            if_busy <= if_busy || fetch_new;
            push    <= valid_wb;
        end
    end

    // in-flight instructions must never share a slot
    always_comb begin
        slot_clash = 1'b0;
        if (valid_id && (valid_ex && s_id == s_ex || valid_mem && s_id == s_mem ||
                         valid_wb && s_id == s_wb))
            slot_clash = 1'b1;
        if (valid_ex && (valid_mem && s_ex == s_mem || valid_wb && s_ex == s_wb))
            slot_clash = 1'b1;
        if (valid_mem && valid_wb && s_mem == s_wb)
            slot_clash = 1'b1;
        if (if_busy && (valid_id && s_if == s_id || valid_ex && s_if == s_ex ||
                        valid_mem && s_if == s_mem || valid_wb && s_if == s_wb))
            slot_clash = 1'b1;
    end

    a_slot_unique: assert property (@(posedge clk) disable iff (rst) !slot_clash);

endmodule

// File: hw/tag_tracker.sv
/*
 * tag tracker
 * hands out a sequential tag at fetch and walks tag and valid through
 * fetch, decode, execute, memory and write-back under stall
 */
`timescale 1ns/10ps

module tag_tracker (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    output logic             fetch_new,
    output logic             leave_id,
    output logic             valid_id,
    output logic             valid_ex,
    output logic             valid_mem,
    output logic             valid_wb,
    output trace_pkg::tag_t  tag_if,
    output trace_pkg::tag_t  tag_id,
    output trace_pkg::tag_t  tag_ex,
    output trace_pkg::tag_t  tag_mem,
    output trace_pkg::tag_t  tag_wb
);

    // tag the next fetched instruction gets
    trace_pkg::tag_t next_tag;
    // fetch holds an instruction, stays set since there is no flush
    logic valid_if;

    ////////////////////////////////////////////////////////////////////////////
    // valid chain
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            next_tag  <= '0;
            valid_if  <= 1'b0;
            fetch_new <= 1'b0;
            valid_id  <= 1'b0;
            valid_ex  <= 1'b0;
            valid_mem <= 1'b0;
            valid_wb  <= 1'b0;
        end else begin
            // a fresh tag sits in fetch for one cycle after each free cycle
            fetch_new <= !stall;
            if (!stall) begin
                next_tag <= next_tag + 1'b1;
                valid_if <= 1'b1;
                valid_id <= valid_if;
            end
            // stall holds decode and feeds a bubble into execute
            valid_ex  <= valid_id && !stall;
            valid_mem <= valid_ex;
            valid_wb  <= valid_mem;
        end
    end

    // tags only mean something where the matching valid is set
    always_ff @(posedge clk) begin
        if (!stall) begin
            tag_if <= next_tag;
            tag_id <= tag_if;
        end
        tag_ex  <= tag_id;
        tag_mem <= tag_ex;
        tag_wb  <= tag_mem;
    end

    // decode hands its instruction on to execute
    assign leave_id = valid_id && !stall;

    // a stalled cycle always leaves a bubble in execute
    a_bubble_after_stall: assert property (
        @(posedge clk) disable iff (rst) stall |=> !valid_ex
    );

endmodule

// File: hw/trace_pkg.sv
/*
 * trace package
 * widths, record layout, register map and bus state encodings shared
 * by the pipeline trace unit
 */
package trace_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // pipeline values
    ////////////////////////////////////////////////////////////////////////////

    // pc, instruction, result, address and write-back data
    typedef logic [31:0] word_t;
    // instruction sequence tag, wraps past 255
    typedef logic [7:0] tag_t;
    // stall cycles spent in fetch and decode, saturates at 255
    typedef logic [7:0] stall_cnt_t;

    // record slots, more than the five instructions in flight
    localparam int TAG_SLOTS = 8;
    localparam int SLOT_W    = $clog2(TAG_SLOTS);
    typedef logic [SLOT_W-1:0] slot_t;

    // word 0 is {16'h0, stall count, tag}, then pc, instr, result, addr, wb data
    localparam int REC_WORDS = 6;
    typedef word_t [REC_WORDS-1:0] rec_t;

    ////////////////////////////////////////////////////////////////////////////
    // retire queue
    ////////////////////////////////////////////////////////////////////////////

    localparam int FIFO_DEPTH = 16;
    localparam int FIFO_PTR_W = $clog2(FIFO_DEPTH);
    typedef logic [FIFO_PTR_W-1:0] fifo_ptr_t;
    // one extra bit so a full queue reads 16
    typedef logic [FIFO_PTR_W:0] fifo_cnt_t;

    ////////////////////////////////////////////////////////////////////////////
    // axi4-lite register map
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [7:0] axil_addr_t;
    typedef logic [1:0] axil_resp_t;
    localparam axil_resp_t RESP_OKAY = 2'b00;

    localparam axil_addr_t REG_STATUS = 8'h00;
    // REC0 to REC5 at 0x04 .. 0x18
    localparam axil_addr_t REG_REC0 = 8'h04;
    localparam axil_addr_t REG_POP = 8'h1C;
    // overflow flag position in STATUS, read and write-to-clear
    localparam int STATUS_OVF_BIT = 8;

    typedef enum logic {RD_IDLE, RD_DATA} axil_rd_state_t;
    typedef enum logic [1:0] {WR_IDLE, WR_ACK, WR_RESP} axil_wr_state_t;

endpackage
